//--- hw/riscv_pkg.sv
package riscv_pkg;

    // data word width
    localparam int xlen = 32;

    // first bios word
    localparam logic [xlen-1:0] reset_pc = 32'h4000_0000;

    // memory map, address bits 31:28
    localparam logic [3:0] region_bios = 4'h4;
    localparam logic [3:0] region_dmem = 4'h1;
    localparam logic [3:0] region_io   = 4'h8;

    // io word offsets, address bits 4:2
    // status bit 0 tx_ready, bit 1 rx_valid
    localparam logic [2:0] io_status  = 3'd0;
    localparam logic [2:0] io_rx_data = 3'd1;
    localparam logic [2:0] io_tx_data = 3'd2;

    // funct3 codes of the kept instructions
    localparam logic [2:0] f3_add = 3'b000;
    localparam logic [2:0] f3_and = 3'b111;
    localparam logic [2:0] f3_beq = 3'b000;
    localparam logic [2:0] f3_bne = 3'b001;

    typedef enum logic [6:0] {
        opc_lui    = 7'b0110111,
        opc_op_imm = 7'b0010011,
        opc_op     = 7'b0110011,
        opc_load   = 7'b0000011,
        opc_store  = 7'b0100011,
        opc_branch = 7'b1100011,
        opc_jal    = 7'b1101111
    } opcode_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4_1;
        logic       imm11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10_1;
        logic       imm11;
        logic [7:0] imm19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_fmt_t;

    // one instruction word, six views of its fields
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        s_fmt_t s;
        b_fmt_t b;
        u_fmt_t u;
        j_fmt_t j;
    } instr_t;

    typedef enum logic [1:0] {
        add    = 2'd0,
        sub    = 2'd1,
        and_op = 2'd2,
        pass_b = 2'd3
    } alu_op_t;

    // source of the load data
    typedef enum logic [1:0] {
        rd_dmem = 2'b00,
        rd_bios = 2'b01,
        rd_io   = 2'b10
    } rd_sel_t;

endpackage

//--- hw/baud_timer.sv
module baud_timer #(
    parameter int CLKS_PER_BIT = 10
)(
    input  logic clk,
    input  logic rst,
    input  logic start,
    input  logic run,
    output logic tick,
    output logic half_tick
);

    localparam int cnt_w = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;
    localparam logic [cnt_w-1:0] cnt_last = cnt_w'(CLKS_PER_BIT - 1);
    // mid-bit point for sampling
    localparam logic [cnt_w-1:0] cnt_half = cnt_w'(CLKS_PER_BIT / 2 - 1);

    logic [cnt_w-1:0] cnt;

    // reload on start and at the end of each period
    always_ff @(posedge clk) begin
        if (rst || start) begin
            cnt <= '0;
        end else if (run) begin
            cnt <= (cnt == cnt_last) ? '0 : cnt + 1'b1;
        end
    end

    assign tick      = run && !start && (cnt == cnt_last);
    assign half_tick = run && !start && (cnt == cnt_half);

endmodule

//--- hw/uart_io.sv
module uart_io
    import riscv_pkg::*;
#(
    parameter int CLKS_PER_BIT = 10
)(
    input  logic            clk,
    input  logic            rst,
    input  logic [2:0]      addr,
    input  logic            io_we,
    input  logic            io_re,
    input  logic [xlen-1:0] wdata,
    output logic [xlen-1:0] io_data,
    input  logic            serial_rx,
    output logic            serial_tx
);

    logic       tx_ready;
    logic       tx_start;
    logic       tx_tick;
    logic [8:0] tx_shift;
    logic [3:0] tx_count;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_busy;
    logic       rx_start;
    logic       rx_sample;
    logic       rx_valid;
    logic [7:0] rx_shift;
    logic [7:0] rx_data;
    logic [3:0] rx_count;

    // a store while busy is ignored
    assign tx_start = io_we && (addr == io_tx_data) && tx_ready;

    baud_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_tx_timer (
        .clk(clk), .rst(rst), .start(tx_start), .run(!tx_ready),
        .tick(tx_tick), .half_tick()
    );

    // start bit goes out at once, then data and stop from the shifter
    always_ff @(posedge clk) begin
        if (rst) begin
            tx_ready  <= 1'b1;
            serial_tx <= 1'b1;
            tx_count  <= 4'd0;
        end else if (tx_start) begin
            tx_ready  <= 1'b0;
            serial_tx <= 1'b0;
            tx_count  <= 4'd0;
        end else if (tx_tick) begin
            if (tx_count == 4'd9) begin
                // end of stop bit
                tx_ready <= 1'b1;
            end else begin
                serial_tx <= tx_shift[0];
                tx_count  <= tx_count + 4'd1;
            end
        end
    end

    // stop bit above the data byte, lsb first
    always_ff @(posedge clk) begin
        if (tx_start) begin
            tx_shift <= {1'b1, wdata[7:0]};
        end else if (tx_tick) begin
            tx_shift <= {1'b1, tx_shift[8:1]};
        end
    end

    // two-flop sync of the async line
    always_ff @(posedge clk) begin
        if (rst) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end else begin
            rx_meta <= serial_rx;
            rx_sync <= rx_meta;
        end
    end

    // low line while idle is taken as a start edge
    assign rx_start = !rx_busy && !rx_sync;

    baud_timer #(
        .CLKS_PER_BIT(CLKS_PER_BIT)
    ) i_rx_timer (
        .clk(clk), .rst(rst), .start(rx_start), .run(rx_busy),
        .tick(), .half_tick(rx_sample)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rx_busy  <= 1'b0;
            rx_valid <= 1'b0;
            rx_count <= 4'd0;
        end else begin
            // read clears, a new byte in the same cycle wins
            if (io_re && addr == io_rx_data) begin
                rx_valid <= 1'b0;
            end
            if (rx_start) begin
                rx_busy  <= 1'b1;
                rx_count <= 4'd0;
            end else if (rx_sample) begin
                rx_count <= rx_count + 4'd1;
                if (rx_count == 4'd0 && rx_sync) begin
                    // glitch, no real start bit
                    rx_busy <= 1'b0;
                end else if (rx_count == 4'd9) begin
                    rx_busy <= 1'b0;
                    if (rx_sync) begin
                        rx_valid <= 1'b1;
                    end
                end
            end
        end
    end

    // data bits at samples 1 to 8, byte kept only on a good stop bit
    always_ff @(posedge clk) begin
        if (rx_sample && rx_count >= 4'd1 && rx_count <= 4'd8) begin
            rx_shift <= {rx_sync, rx_shift[7:1]};
        end
        if (rx_sample && rx_count == 4'd9 && rx_sync) begin
            rx_data <= rx_shift;
        end
    end

    // registered read port, one cycle like the memories
    always_ff @(posedge clk) begin
        if (io_re) begin
            case (addr)
                io_status:  io_data <= {{(xlen-2){1'b0}}, rx_valid, tx_ready};
                io_rx_data: io_data <= {{(xlen-8){1'b0}}, rx_data};
                default:    io_data <= '0;
            endcase
        end
    end

endmodule

//--- hw/bios_rom.sv
module bios_rom
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic [9:0]      adra,
    input  logic [9:0]      adrb,
    output logic [xlen-1:0] douta,
    output logic [xlen-1:0] doutb
);

    logic [xlen-1:0] mem [1024];

    // program image
    initial begin
        $readmemh("sim/bios.hex", mem);
    end

    // a for fetch, b for loads, both registered
    always_ff @(posedge clk) begin
        douta <= mem[adra];
        doutb <= mem[adrb];
    end

endmodule

//--- hw/dmem.sv
module dmem
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic [9:0]      addr,
    input  logic [xlen-1:0] din,
    input  logic [3:0]      wea,
    output logic [xlen-1:0] dout
);

    logic [xlen-1:0] mem [1024];

    // byte lanes written independently
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (wea[b]) begin
                mem[addr][8*b +: 8] <= din[8*b +: 8];
            end
        end
        // read returns the old word on a write
        dout <= mem[addr];
    end

endmodule

//--- hw/mem_control.sv
module mem_control
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] addr,
    input  logic [3:0]      wea,
    input  logic            mem_rd,
    input  logic [xlen-1:0] dmem_data,
    input  logic [xlen-1:0] bios_data,
    input  logic [xlen-1:0] io_data,
    output logic [3:0]      dmem_wea,
    output logic            io_we,
    output logic            io_re,
    output logic [xlen-1:0] rdata
);

    logic [3:0] region;
    rd_sel_t    rd_sel;

    assign region = addr[31:28];

    // stores outside dmem and io are dropped
    assign dmem_wea = (region == region_dmem) ? wea : 4'h0;
    assign io_we    = (region == region_io) && (|wea);
    assign io_re    = mem_rd && (region == region_io);

    // region of the load, one cycle behind like the memories
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_sel <= rd_dmem;
        end else if (mem_rd) begin
            case (region)
                region_bios: rd_sel <= rd_bios;
                region_io:   rd_sel <= rd_io;
                default:     rd_sel <= rd_dmem;
            endcase
        end
    end

    always_comb begin
        case (rd_sel)
            rd_dmem: rdata = dmem_data;
            rd_bios: rdata = bios_data;
            rd_io:   rdata = io_data;
            default: rdata = '0;
        endcase
    end

    a_bios_read_only: assert property (
        @(posedge clk) disable iff (rst) (|wea) |-> (region != region_bios)
    );

endmodule

//--- hw/data_path.sv
module data_path
    import riscv_pkg::*;
(
    input  logic            clk,
    input  logic            rst,
    input  logic [xlen-1:0] fetch_data,
    input  logic [xlen-1:0] rdata,
    input  logic            pc_we,
    input  logic            ir_we,
    input  logic            rf_we,
    input  alu_op_t         alu_op,
    input  logic            use_imm,
    input  logic            mem_wr,
    input  logic            wb_from_mem,
    input  logic            branch,
    input  logic            jump,
    output logic [xlen-1:0] pc,
    output logic [xlen-1:0] addr,
    output logic [xlen-1:0] wdata,
    output logic [3:0]      wea,
    output instr_t          instr
);

    logic [xlen-1:0] regs [32];
    logic [xlen-1:0] rs1_val;
    logic [xlen-1:0] rs2_val;
    logic [xlen-1:0] imm_i;
    logic [xlen-1:0] imm_s;
    logic [xlen-1:0] imm_b;
    logic [xlen-1:0] imm_u;
    logic [xlen-1:0] imm_j;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] alu_out;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] target;
    logic [xlen-1:0] wb_val;
    logic            eq;
    logic            taken;

    // instruction register
    always_ff @(posedge clk) begin
        if (ir_we) begin
            instr <= fetch_data;
        end
    end

    // immediates, sign extended from bit 31
    assign imm_i = {{20{instr.i.imm[11]}}, instr.i.imm};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{19{instr.b.imm12}}, instr.b.imm12, instr.b.imm11,
                    instr.b.imm10_5, instr.b.imm4_1, 1'b0};
    assign imm_u = {instr.u.imm, 12'b0};
    assign imm_j = {{11{instr.j.imm20}}, instr.j.imm20, instr.j.imm19_12,
                    instr.j.imm11, instr.j.imm10_1, 1'b0};

    always_comb begin
        case (opcode_t'(instr.r.opcode))
            opc_lui:    imm = imm_u;
            opc_store:  imm = imm_s;
            opc_branch: imm = imm_b;
            opc_jal:    imm = imm_j;
            default:    imm = imm_i;
        endcase
    end

    // x0 reads as zero and is never written
    assign rs1_val = (instr.r.rs1 == 5'd0) ? '0 : regs[instr.r.rs1];
    assign rs2_val = (instr.r.rs2 == 5'd0) ? '0 : regs[instr.r.rs2];

    assign op_b = use_imm ? imm : rs2_val;

    always_comb begin
        case (alu_op)
            add:     alu_result = rs1_val + op_b;
            sub:     alu_result = rs1_val - op_b;
            and_op:  alu_result = rs1_val & op_b;
            default: alu_result = op_b;
        endcase
    end

    // holds steady through mem and writeback since ir does
    always_ff @(posedge clk) begin
        alu_out <= alu_result;
    end

    // beq and bne
    assign eq    = rs1_val == rs2_val;
    assign taken = branch && ((instr.b.funct3 == f3_beq && eq) ||
                              (instr.b.funct3 == f3_bne && !eq));

    assign pc_plus4 = pc + 32'd4;
    assign target   = pc + imm;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= reset_pc;
        end else if (pc_we) begin
            pc <= (jump || taken) ? target : pc_plus4;
        end
    end

    // jal links the next pc
    assign wb_val = wb_from_mem ? rdata : (jump ? pc_plus4 : alu_out);

    always_ff @(posedge clk) begin
        if (rf_we && instr.r.rd != 5'd0) begin
            regs[instr.r.rd] <= wb_val;
        end
    end

    assign addr  = alu_out;
    assign wdata = rs2_val;
    assign wea   = {4{mem_wr}};

    // word stores land on a word boundary
    a_word_store: assert property (
        @(posedge clk) disable iff (rst) (|wea) |-> (addr[1:0] == 2'b00)
    );

endmodule

//--- hw/core_fsm.sv
module core_fsm
    import riscv_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  instr_t  instr,
    output logic    pc_we,
    output logic    ir_we,
    output logic    rf_we,
    output alu_op_t alu_op,
    output logic    use_imm,
    output logic    mem_rd,
    output logic    mem_wr,
    output logic    wb_from_mem,
    output logic    branch,
    output logic    jump
);

    // one-hot step encoding
    localparam logic [4:0] s_fetch     = 5'b00001;
    localparam logic [4:0] s_decode    = 5'b00010;
    localparam logic [4:0] s_execute   = 5'b00100;
    localparam logic [4:0] s_mem       = 5'b01000;
    localparam logic [4:0] s_writeback = 5'b10000;

    logic [4:0] state;
    logic [4:0] next_state;
    opcode_t    opcode;
    logic       is_load;
    logic       is_store;
    logic       writes_rd;

    // ir is valid from execute on
    assign opcode    = opcode_t'(instr.r.opcode);
    assign is_load   = opcode == opc_load;
    assign is_store  = opcode == opc_store;
    assign writes_rd = opcode inside {opc_lui, opc_op_imm, opc_op, opc_load, opc_jal};

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= s_fetch;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        case (state)
            s_fetch:     next_state = s_decode;
            s_decode:    next_state = s_execute;
            // memory ops take the extra step, all others go to writeback
            s_execute:   next_state = (is_load || is_store) ? s_mem : s_writeback;
            // a store ends in mem
            s_mem:       next_state = is_load ? s_writeback : s_fetch;
            s_writeback: next_state = s_fetch;
            default:     next_state = s_fetch;
        endcase
    end

    // alu function and operand b per opcode
    always_comb begin
        alu_op  = add;
        use_imm = 1'b1;
        case (opcode)
            opc_lui: begin
                alu_op = pass_b;
            end
            opc_op_imm: begin
                if (instr.i.funct3 == f3_and) begin
                    alu_op = and_op;
                end
            end
            opc_op: begin
                use_imm = 1'b0;
                if (instr.r.funct3 == f3_and) begin
                    alu_op = and_op;
                end else if (instr.r.funct3 == f3_add && instr.r.funct7[5]) begin
                    alu_op = sub;
                end
            end
            default: begin
                alu_op = add;
            end
        endcase
    end

    // ir loads while the rom output is valid
    assign ir_we       = state == s_decode;
    // pc moves on the last step of every instruction
    assign pc_we       = (state == s_writeback) || (state == s_mem && is_store);
    assign rf_we       = (state == s_writeback) && writes_rd;
    assign mem_rd      = (state == s_mem) && is_load;
    assign mem_wr      = (state == s_mem) && is_store;
    assign wb_from_mem = is_load;
    assign branch      = opcode == opc_branch;
    assign jump        = opcode == opc_jal;

    // only lw and sw reach the mem step
    a_word_access: assert property (
        @(posedge clk) disable iff (rst) (mem_rd || mem_wr) |-> (instr.r.funct3 == 3'b010)
    );

    // the fetched word is one of the kept opcodes
    a_opcode_kept: assert property (
        @(posedge clk) disable iff (rst)
        (state == s_execute) |->
        (opcode inside {opc_lui, opc_op_imm, opc_op, opc_load, opc_store, opc_branch, opc_jal})
    );

endmodule

//--- hw/riscv151.sv
module riscv151
    import riscv_pkg::*;
#(
    parameter int CPU_CLOCK_FREQ = 50_000_000,
    parameter int BAUD_RATE      = 115_200
)(
    input  logic clk,
    input  logic rst,
    // off-chip serial pins
    input  logic serial_rx,
    output logic serial_tx
);

    // rounded clocks per serial bit
    localparam int clks_per_bit = (CPU_CLOCK_FREQ + BAUD_RATE / 2) / BAUD_RATE;

    logic [xlen-1:0] pc;
    logic [xlen-1:0] addr;
    logic [xlen-1:0] wdata;
    logic [3:0]      wea;
    instr_t          instr;
    logic [xlen-1:0] fetch_data;
    logic [xlen-1:0] bios_data;
    logic [xlen-1:0] dmem_data;
    logic [xlen-1:0] io_data;
    logic [xlen-1:0] rdata;
    logic [3:0]      dmem_wea;
    logic            io_we;
    logic            io_re;

    // fsm controls
    logic    pc_we;
    logic    ir_we;
    logic    rf_we;
    alu_op_t alu_op;
    logic    use_imm;
    logic    mem_rd;
    logic    mem_wr;
    logic    wb_from_mem;
    logic    branch;
    logic    jump;

    core_fsm i_core_fsm (
        .clk(clk), .rst(rst), .instr(instr),
        .pc_we(pc_we), .ir_we(ir_we), .rf_we(rf_we), .alu_op(alu_op),
        .use_imm(use_imm), .mem_rd(mem_rd), .mem_wr(mem_wr),
        .wb_from_mem(wb_from_mem), .branch(branch), .jump(jump)
    );

    data_path i_data_path (
        .clk(clk), .rst(rst), .fetch_data(fetch_data), .rdata(rdata),
        .pc_we(pc_we), .ir_we(ir_we), .rf_we(rf_we), .alu_op(alu_op),
        .use_imm(use_imm), .mem_wr(mem_wr), .wb_from_mem(wb_from_mem),
        .branch(branch), .jump(jump),
        .pc(pc), .addr(addr), .wdata(wdata), .wea(wea), .instr(instr)
    );

    mem_control i_mem_control (
        .clk(clk), .rst(rst), .addr(addr), .wea(wea), .mem_rd(mem_rd),
        .dmem_data(dmem_data), .bios_data(bios_data), .io_data(io_data),
        .dmem_wea(dmem_wea), .io_we(io_we), .io_re(io_re), .rdata(rdata)
    );

    // port a fetches at pc, port b serves loads
    bios_rom i_bios_rom (
        .clk(clk), .adra(pc[11:2]), .adrb(addr[11:2]),
        .douta(fetch_data), .doutb(bios_data)
    );

    dmem i_dmem (
        .clk(clk), .addr(addr[11:2]), .din(wdata), .wea(dmem_wea), .dout(dmem_data)
    );

    uart_io #(
        .CLKS_PER_BIT(clks_per_bit)
    ) i_uart_io (
        .clk(clk), .rst(rst), .addr(addr[4:2]), .io_we(io_we), .io_re(io_re),
        .wdata(wdata), .io_data(io_data),
        .serial_rx(serial_rx), .serial_tx(serial_tx)
    );

endmodule

//--- sim/riscv151_tb.sv
module riscv151_tb;

    timeunit 1ns;
    timeprecision 1ps;

    // serial rate of the test, 10 clocks per bit
    localparam int cpu_clock_freq = 1_000_000;
    localparam int baud_rate      = 100_000;
    localparam int clks_per_bit   = cpu_clock_freq / baud_rate;
    localparam int reset_cycles   = 8;
    localparam int idle_cycles    = 200;
    localparam int reply_timeout  = 2000;
    localparam int random_count   = 20;

    localparam logic [7:0] cr = 8'h0d;

    // two lines that end in a carriage return
    localparam logic [7:0] group_a [5] = '{8'h31, 8'h32, 8'h33, 8'h7a, 8'h80};
    localparam logic [7:0] group_b [4] = '{8'hc8, 8'hc8, 8'h05, 8'h0a};

    logic clk;
    logic rst;
    logic serial_rx;
    logic serial_tx;

    // bytes seen on serial_tx, and what they should be
    logic [7:0]  tx_frames [$];
    logic [7:0]  expected_q [$];
    int          errors;
    int          replies;
    logic        timed_out;
    logic [31:0] line_sum;
    integer      seed;

    riscv151 #(
        .CPU_CLOCK_FREQ(cpu_clock_freq),
        .BAUD_RATE(baud_rate)
    ) i_dut (
        .clk(clk),
        .rst(rst),
        .serial_rx(serial_rx),
        .serial_tx(serial_tx)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // reply for one byte given the sum of the line so far
    function automatic logic [7:0] expected_reply(input logic [7:0] b, input logic [31:0] sum);
        if (b == cr) begin
            return sum[7:0];
        end else begin
            return b + 8'd1;
        end
    endfunction

    // one frame into serial_rx, lsb first
    task automatic drive_byte(input logic [7:0] b);
        @(posedge clk);
        serial_rx <= 1'b0;
        repeat (clks_per_bit) @(posedge clk);
        for (int i = 0; i < 8; i++) begin
            serial_rx <= b[i];
            repeat (clks_per_bit) @(posedge clk);
        end
        // stop bit
        serial_rx <= 1'b1;
        repeat (clks_per_bit) @(posedge clk);
    endtask

    // start edge already seen on this negedge
    task automatic capture_frame(output logic [7:0] data);
        // to the middle of the start bit
        repeat (clks_per_bit / 2) @(negedge clk);
        if (serial_tx !== 1'b0) begin
            $display("framing error: start bit of a serial_tx frame was not low at mid-bit");
            errors++;
        end
        for (int i = 0; i < 8; i++) begin
            repeat (clks_per_bit) @(negedge clk);
            data[i] = serial_tx;
        end
        repeat (clks_per_bit) @(negedge clk);
        if (serial_tx !== 1'b1) begin
            $display("framing error: stop bit of a serial_tx frame was not high at mid-bit");
            errors++;
        end
    endtask

    // line must stay high with no input
    task automatic check_idle();
        int low_cycles;
        low_cycles = 0;
        repeat (idle_cycles) begin
            @(negedge clk);
            if (serial_tx !== 1'b1) begin
                low_cycles++;
            end
        end
        if (low_cycles != 0) begin
            $display("serial_tx went low on %0d of %0d idle cycles after reset",
                     low_cycles, idle_cycles);
            errors++;
        end
    endtask

    task automatic pick_random_byte(output logic [7:0] b);
        logic [31:0] rnd;
        rnd = $random(seed);
        b = rnd[7:0];
        // a carriage return would close the line early
        while (b == cr) begin
            rnd = $random(seed);
            b = rnd[7:0];
        end
    endtask

    // send one byte and wait for its reply to be compared
    task automatic send_and_check(input logic [7:0] b);
        logic [7:0] exp;
        int         target;
        int         waited;
        if (!timed_out) begin
            exp = expected_reply(b, line_sum);
            if (b == cr) begin
                line_sum = 32'h0;
            end else begin
                line_sum = line_sum + {24'h0, b};
            end
            expected_q.push_back(exp);
            target = replies + 1;
            drive_byte(b);
            waited = 0;
            while (replies < target && waited < reply_timeout) begin
                @(posedge clk);
                waited++;
            end
            if (replies < target) begin
                $display("timeout: the reply to byte 0x%02h never arrived on serial_tx", b);
                errors++;
                timed_out = 1'b1;
            end
        end
    endtask

    task automatic finish_run();
        $display("replies checked: %0d, errors: %0d", replies, errors);
        if (errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    endtask

    // frames decoded from serial_tx
    initial begin : tx_monitor
        logic [7:0] data;
        forever begin
            @(negedge clk);
            if (!rst && serial_tx === 1'b0) begin
                capture_frame(data);
                tx_frames.push_back(data);
            end
        end
    end

    // each decoded frame against the oldest expected reply
    always @(negedge clk) begin : compare_replies
        logic [7:0] got;
        logic [7:0] exp;
        if (tx_frames.size() > 0) begin
            got = tx_frames.pop_front();
            if (expected_q.size() == 0) begin
                $display("unexpected frame 0x%02h on serial_tx with no byte outstanding", got);
                errors++;
            end else begin
                exp = expected_q.pop_front();
                if (got !== exp) begin
                    $display("ERROR serial_tx: expected 0x%02h, received 0x%02h", exp, got);
                    errors++;
                end
                replies++;
            end
        end
    end

    initial begin : stimulus
        logic [7:0] b;
        rst       = 1'b1;
        serial_rx = 1'b1;
        errors    = 0;
        replies   = 0;
        timed_out = 1'b0;
        line_sum  = 32'h0;
        seed      = 32'hd0a7_29d4;
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;

        // quiet line after reset
        check_idle();

        // plain echo, then wrap through the 8-bit mask
        send_and_check(8'h41);
        send_and_check(8'hff);

        for (int n = 0; n < random_count; n++) begin
            pick_random_byte(b);
            send_and_check(b);
        end

        // closes everything sent so far
        send_and_check(cr);

        // each line returns only its own sum
        for (int n = 0; n < 5; n++) begin
            send_and_check(group_a[n]);
        end
        send_and_check(cr);
        for (int n = 0; n < 4; n++) begin
            send_and_check(group_b[n]);
        end
        send_and_check(cr);

        // window for stray frames
        repeat (300) @(posedge clk);
        finish_run();
    end

endmodule

//--- sim/bios.hex
// bios image, one instruction word per line, word 0 at 0x4000_0000
// uart echo of byte plus one, carriage return answers the line sum
800000b7 // lui  x1, 0x80000      io base
10000137 // lui  x2, 0x10000      dmem base, word 0 is the sum
00d00213 // addi x4, x0, 13       carriage return
00012023 // sw   x0, 0(x2)        clear sum
00410293 // addi x5, x2, 4        line buffer
0000a303 // lw   x6, 0(x1)        rx_wait: status
00237313 // andi x6, x6, 2        rx_valid
fe030ce3 // beq  x6, x0, rx_wait
0040a383 // lw   x7, 4(x1)        rx byte
0072a023 // sw   x7, 0(x5)        keep in buffer
00428293 // addi x5, x5, 4
00439a63 // bne  x7, x4, not_cr
00012483 // lw   x9, 0(x2)        reply is the sum
00012023 // sw   x0, 0(x2)        restart sum
00410293 // addi x5, x2, 4        restart buffer
0140006f // jal  x0, send
00012403 // lw   x8, 0(x2)        not_cr
00740433 // add  x8, x8, x7
00812023 // sw   x8, 0(x2)
00138493 // addi x9, x7, 1        byte plus one
0ff4f493 // andi x9, x9, 0xff     send
0000a303 // lw   x6, 0(x1)        tx_wait: status
00137313 // andi x6, x6, 1        tx_ready
fe030ce3 // beq  x6, x0, tx_wait
0090a423 // sw   x9, 8(x1)        tx data
fb1ff06f // jal  x0, rx_wait

//--- verilog.f
hw/riscv_pkg.sv
hw/baud_timer.sv
hw/uart_io.sv
hw/bios_rom.sv
hw/dmem.sv
hw/mem_control.sv
hw/data_path.sv
hw/core_fsm.sv
hw/riscv151.sv
sim/riscv151_tb.sv

//--- run_sim.sh
#!/bin/sh
# build with verilator, run from the project root, then scan the log
verilator --binary --timing --assert -f verilog.f --top-module riscv151_tb -o riscv151_sim \
    && ./obj_dir/riscv151_sim > sim.log \
    && cat sim.log \
    && ! grep -q "Verification failed" sim.log \
    || { echo "simulation run failed"; exit 1; }
